//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module corr_tb \
		-f list.f -o corr_sim
	./obj_dir/corr_sim | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/corr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module corr_tb import corr_pkg::*; ();

  // sample cycles of all tests: constant, random, gaps, back-pressure, overrun
  localparam int SAMPLE_CYCLES = 3 * 2 * (1 + 2 + 16 + 256) + 20 * 8 + 20 * 8 + 12 * 16 + 10;
  localparam int CYCLE_LIMIT   = 2 * SAMPLE_CYCLES + 2000;

  logic              i_clk;
  logic              i_arst_n;
  logic              i_enable;
  logic              i_x;
  logic              i_y;
  logic [EXP_W-1:0]  i_window_exp;
  logic              i_res_credit;
  logic              o_res_valid;
  logic [DATA_W-1:0] o_res_count_x;
  logic [DATA_W-1:0] o_res_count_y;
  logic [DATA_W-1:0] o_res_count_isect;
  logic [DATA_W-1:0] o_res_count_symdiff;
  logic [SEQ_W-1:0]  o_res_seq;
  logic              o_overrun;

  corr_counts_t      exp_cnt [64];   // expected windows in sample order
  logic [SEQ_W-1:0]  exp_seq [64];
  int                wr_idx;         // written by the stimulus
  int                rd_idx;         // advanced by the monitor
  int                rx_cnt;         // results seen since reset
  int                ret_cnt;        // credits seen since reset
  int                mon_err;
  int                chk_err;
  int                n_pass;
  int                n_fail;
  int                max_delay;
  int                cycles;
  bit                hold_credits;
  string             cur_test;

  corr_top u_corr_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // expected counts straight from the weight rule, DATA_W wraparound
  function automatic corr_counts_t ref_counts(input logic [255:0] xs, input logic [255:0] ys,
                                              input int e);
    corr_counts_t      r;
    logic [DATA_W-1:0] w;
    r = '0;
    w = (e == 0) ? DATA_W'(INCR_MAX) : DATA_W'(INCR_MAX >> (e - 1));
    for (int i = 0; i < (1 << e); i++) begin
      if (xs[i]) r.x = r.x + w;
      if (ys[i]) r.y = r.y + w;
      if (xs[i] && ys[i]) r.isect = r.isect + w;
      if (xs[i] != ys[i]) r.symdiff = r.symdiff + w;
    end
    return r;
  endfunction

  function automatic logic pick_bit(input int mode);
    return (mode == 2) ? 1'($urandom_range(1, 0)) : mode[0];  // 2 means random
  endfunction

  task automatic check_field(input string what, input logic [DATA_W-1:0] e,
                             input logic [DATA_W-1:0] a);
    assert (a === e) else begin
      $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, e, a);
      mon_err++;
    end
  endtask

  // result monitor, sampled on the rising edge
  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_idx  = 0;
      rx_cnt  = 0;
      ret_cnt = 0;
    end else begin
      if (o_res_valid) begin
        assert ((rx_cnt - ret_cnt) < CREDITS) else begin
          $display("%s: result sent while all credits were spent", cur_test);
          mon_err++;
        end
        if (rd_idx >= wr_idx) begin
          $display("%s: result with seq %0d arrived but none was expected", cur_test, o_res_seq);
          mon_err++;
        end else begin
          check_field("seq", DATA_W'(exp_seq[rd_idx]), DATA_W'(o_res_seq));
          check_field("x", exp_cnt[rd_idx].x, o_res_count_x);
          check_field("y", exp_cnt[rd_idx].y, o_res_count_y);
          check_field("isect", exp_cnt[rd_idx].isect, o_res_count_isect);
          check_field("symdiff", exp_cnt[rd_idx].symdiff, o_res_count_symdiff);
          rd_idx++;
        end
        rx_cnt++;
      end
      if (i_res_credit) ret_cnt++;
    end
  end

  // credit-returning sink, one credit per result after a random wait
  initial begin : sink
    int delay_left;
    i_res_credit = 1'b0;
    delay_left   = -1;
    forever begin
      @(negedge i_clk);
      i_res_credit = 1'b0;
      if (!i_arst_n) begin
        delay_left = -1;
      end else if (!hold_credits && (rx_cnt - ret_cnt) > 0) begin
        if (delay_left < 0) delay_left = int'($urandom_range(max_delay, 0));
        if (delay_left == 0) begin
          i_res_credit = 1'b1;
          delay_left   = -1;
        end else begin
          delay_left--;
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout after %0d cycles in %s, results never arrived", cycles, cur_test);
    $display("Simulation failed");
    $finish;
  end

  task automatic apply_reset(input int e);
    i_arst_n     = 1'b0;
    i_enable     = 1'b0;
    i_x          = 1'b0;
    i_y          = 1'b0;
    i_window_exp = EXP_W'(e);     // stable before the first enable
    hold_credits = 1'b0;
    wr_idx       = 0;
    repeat (3) @(negedge i_clk);
    i_arst_n     = 1'b1;
  endtask

  // keep limits how many windows are expected to come out
  task automatic run_windows(input int e, input int n_win, input int keep,
                             input int xm, input int ym, input int gap_pct);
    logic [255:0] xs;
    logic [255:0] ys;
    for (int w = 0; w < n_win; w++) begin
      xs = '0;
      ys = '0;
      for (int s = 0; s < (1 << e); s++) begin
        while (int'($urandom_range(99, 0)) < gap_pct) begin
          i_enable = 1'b0;
          i_x      = 1'($urandom_range(1, 0));   // ignored while disabled
          i_y      = 1'($urandom_range(1, 0));
          @(negedge i_clk);
        end
        xs[s]    = pick_bit(xm);
        ys[s]    = pick_bit(ym);
        i_enable = 1'b1;
        i_x      = xs[s];
        i_y      = ys[s];
        @(negedge i_clk);
      end
      if (w < keep) begin
        exp_cnt[wr_idx] = ref_counts(xs, ys, e);
        exp_seq[wr_idx] = SEQ_W'(w);
        wr_idx++;
      end
    end
    i_enable = 1'b0;
  endtask

  task automatic drain();
    while (rd_idx < wr_idx) @(negedge i_clk);
    repeat (5) @(negedge i_clk);   // room for a stray extra result
  endtask

  task automatic end_test(input int err0);
    if (mon_err + chk_err == err0) begin
      n_pass++;
      $display("test %s: ok", cur_test);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", cur_test, mon_err + chk_err - err0);
    end
  endtask

  task automatic run_test(input string name, input int e, input int n_win, input int xm,
                          input int ym, input int gap_pct, input int maxd);
    int err0;
    cur_test  = name;
    max_delay = maxd;
    apply_reset(e);
    err0 = mon_err + chk_err;
    run_windows(e, n_win, n_win, xm, ym, gap_pct);
    drain();
    assert (o_overrun === 1'b0) else begin
      $display("%s: overrun flag set although no window was dropped", name);
      chk_err++;
    end
    end_test(err0);
  endtask

  initial begin : main
    int err0;
    int exps [4];
    void'($urandom(64871));
    mon_err   = 0;
    chk_err   = 0;
    n_pass    = 0;
    n_fail    = 0;
    max_delay = 5;
    cur_test  = "reset";
    exps      = '{0, 1, 4, 8};
    apply_reset(0);

    foreach (exps[i]) begin
      run_test($sformatf("const_xy_e%0d", exps[i]), exps[i], 3, 1, 1, 0, 5);
      run_test($sformatf("const_x_e%0d", exps[i]), exps[i], 3, 1, 0, 0, 5);
    end
    run_test("random_e3", 3, 20, 2, 2, 0, 5);
    run_test("enable_gaps", 3, 20, 2, 2, 25, 5);
    run_test("backpressure", 4, 12, 2, 2, 0, 30);

    // 4 go out on the initial credits, 4 wait, the last 2 are dropped
    cur_test  = "overrun";
    max_delay = 5;
    apply_reset(0);
    hold_credits = 1'b1;
    err0 = mon_err + chk_err;
    run_windows(0, 10, 8, 1, 2, 0);
    repeat (4) @(negedge i_clk);
    assert (rx_cnt == CREDITS) else begin
      $display("FAIL overrun sent before credit return: expected %0d, actual %0d",
               CREDITS, rx_cnt);
      chk_err++;
    end
    assert (o_overrun === 1'b1) else begin
      $display("overrun: flag stayed low although the queue was full");
      chk_err++;
    end
    hold_credits = 1'b0;
    drain();
    assert (rx_cnt == 8) else begin
      $display("FAIL overrun received: expected %0d, actual %0d", 8, rx_cnt);
      chk_err++;
    end
    end_test(err0);

    $display("tests ok: %0d, tests with errors: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
logic/corr_pkg.sv
logic/corr_count_if.sv
logic/corr_window_timer.sv
logic/corr_count_rect.sv
logic/corr_result_sender.sv
logic/corr_top.sv
bench/corr_tb.sv

//--- logic/corr_count_if.sv
`timescale 1ns/1ps
`default_nettype none

// finished-window hand-off from the counter block to the result sender.
// there is no ready; the sender has to take or drop every window itself
interface corr_count_if import corr_pkg::*; ();

  logic         done;     // single-cycle pulse, one cycle after the last sample
  corr_counts_t counts;   // full window totals, valid while done is high

  modport source (
    output done,
    output counts
  );

  modport sink (
    input done,
    input counts
  );

endinterface

`default_nettype wire

//--- logic/corr_count_rect.sv
`timescale 1ns/1ps
`default_nettype none

module corr_count_rect import corr_pkg::*; (
  input  wire              i_clk,
  input  wire              i_arst_n,
  input  wire              i_sample,
  input  wire              i_first,
  input  wire              i_last,
  input  wire              i_x,
  input  wire              i_y,
  input  wire [EXP_W-1:0]  i_exp,
  corr_count_if.source     cnt
);

  logic [INCR_W-1:0] incr_d;
  logic [INCR_W-1:0] incr_q;
  logic [DATA_W-1:0] incr;          // weight widened to the count width
  logic [3:0]        hit;           // x, y, isect, symdiff
  logic [DATA_W-1:0] acc_q [4];
  logic              done_q;

  // weight normalises the result across window lengths
  always_comb begin
    if (i_exp == '0) begin
      incr_d = INCR_MAX;
    end else begin
      incr_d = INCR_MAX >> (i_exp - EXP_W'(1));
    end
  end

  // exponent only moves while the timer is idle, so loading every cycle is safe
  always_ff @(posedge i_clk) begin
    incr_q <= incr_d;
  end

  assign incr = {{TIME_W{1'b0}}, incr_q};

  assign hit[0] = i_x;
  assign hit[1] = i_y;
  assign hit[2] = i_x & i_y;
  assign hit[3] = i_x ^ i_y;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 4; i++) begin
        acc_q[i] <= '0;
      end
    end else if (i_sample) begin
      for (int i = 0; i < 4; i++) begin
        if (i_first) begin
          acc_q[i] <= hit[i] ? incr : '0;      // first sample replaces the old total
        end else if (hit[i]) begin
          acc_q[i] <= acc_q[i] + incr;         // wraps at DATA_W
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= i_last;                        // totals are complete one cycle later
    end
  end

  // accumulators still hold the old window even if a new one starts this cycle
  assign cnt.done           = done_q;
  assign cnt.counts.x       = acc_q[0];
  assign cnt.counts.y       = acc_q[1];
  assign cnt.counts.isect   = acc_q[2];
  assign cnt.counts.symdiff = acc_q[3];

endmodule

`default_nettype wire

//--- logic/corr_pkg.sv
`default_nettype none

package corr_pkg;

  localparam int DATA_W      = 16;                    // width of each count
  localparam int TIME_W      = 8;                     // largest window exponent
  localparam int EXP_W       = $clog2(TIME_W + 1);    // holds 0 .. TIME_W
  localparam int INCR_W      = DATA_W - TIME_W;       // weight width

  localparam logic [INCR_W-1:0] INCR_MAX = {INCR_W{1'b1}};

  localparam int CREDITS     = 4;                     // matches sink buffer depth
  localparam int CRED_W      = $clog2(CREDITS + 1);
  localparam int QUEUE_DEPTH = 4;                     // power of two, pointers wrap
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int SEQ_W       = 8;

  // one finished window
  typedef struct packed {
    logic [DATA_W-1:0] x;
    logic [DATA_W-1:0] y;
    logic [DATA_W-1:0] isect;     // x and y
    logic [DATA_W-1:0] symdiff;   // x xor y
  } corr_counts_t;

  typedef enum logic {
    IDLE,
    RUN
  } timer_state_e;

endpackage

`default_nettype wire

//--- logic/corr_result_sender.sv
`timescale 1ns/1ps
`default_nettype none

module corr_result_sender import corr_pkg::*; (
  input  wire               i_clk,
  input  wire               i_arst_n,
  corr_count_if.sink        cnt,
  input  wire               i_res_credit,
  output logic              o_res_valid,
  output corr_counts_t      o_res_counts,
  output logic [SEQ_W-1:0]  o_res_seq,
  output logic              o_overrun
);

  corr_counts_t      q_counts [QUEUE_DEPTH];
  logic [SEQ_W-1:0]  q_seq [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QPTR_W:0]   fill_q;        // entries waiting
  logic [SEQ_W-1:0]  seq_q;         // number of the next finished window
  logic [CRED_W-1:0] credit_q;
  logic              full;
  logic              push;
  logic              pop;

  assign full = (fill_q == (QPTR_W + 1)'(QUEUE_DEPTH));
  assign pop  = (fill_q != '0) && (credit_q != '0);   // send head whenever a credit is held
  assign push = cnt.done && (!full || pop);           // slot freed by pop can be refilled

  assign o_res_valid  = pop;
  assign o_res_counts = q_counts[rd_ptr_q];
  assign o_res_seq    = q_seq[rd_ptr_q];

  always_ff @(posedge i_clk) begin
    if (push) begin
      q_counts[wr_ptr_q] <= cnt.counts;
      q_seq[wr_ptr_q]    <= seq_q;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      fill_q    <= '0;
      seq_q     <= '0;
      credit_q  <= CRED_W'(CREDITS);
      o_overrun <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + QPTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + QPTR_W'(1);
      end
      fill_q <= fill_q + (QPTR_W + 1)'(push) - (QPTR_W + 1)'(pop);

      if (cnt.done) begin
        seq_q <= seq_q + 1'b1;            // dropped windows still consume a number
      end
      if (cnt.done && !push) begin
        o_overrun <= 1'b1;                // sticky until reset
      end

      credit_q <= credit_q + CRED_W'(i_res_credit) - CRED_W'(pop);
    end
  end

  // sink must never hand back more credits than it was given
  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    credit_q <= CRED_W'(CREDITS));

  // out of credit and nothing returned: no send next cycle and the count stays at zero
  a_no_credit_no_send: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ((credit_q == '0) && !i_res_credit) |=> (!o_res_valid && (credit_q == '0)));

endmodule

`default_nettype wire

//--- logic/corr_top.sv
`timescale 1ns/1ps
`default_nettype none

module corr_top import corr_pkg::*; (
  input  wire               i_clk,
  input  wire               i_arst_n,
  input  wire               i_enable,
  input  wire               i_x,
  input  wire               i_y,
  input  wire  [EXP_W-1:0]  i_window_exp,
  input  wire               i_res_credit,
  output logic              o_res_valid,
  output logic [DATA_W-1:0] o_res_count_x,
  output logic [DATA_W-1:0] o_res_count_y,
  output logic [DATA_W-1:0] o_res_count_isect,
  output logic [DATA_W-1:0] o_res_count_symdiff,
  output logic [SEQ_W-1:0]  o_res_seq,
  output logic              o_overrun
);

  logic             sample;
  logic             first;
  logic             last;
  logic [EXP_W-1:0] win_exp;
  corr_counts_t     res_counts;

  corr_count_if u_cnt_if ();

  corr_window_timer u_timer (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_enable     (i_enable),
    .i_window_exp (i_window_exp),
    .o_sample     (sample),
    .o_first      (first),
    .o_last       (last),
    .o_exp        (win_exp)
  );

  corr_count_rect u_count (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sample (sample),
    .i_first  (first),
    .i_last   (last),
    .i_x      (i_x),
    .i_y      (i_y),
    .i_exp    (win_exp),
    .cnt      (u_cnt_if.source)
  );

  corr_result_sender u_sender (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .cnt          (u_cnt_if.sink),
    .i_res_credit (i_res_credit),
    .o_res_valid  (o_res_valid),
    .o_res_counts (res_counts),
    .o_res_seq    (o_res_seq),
    .o_overrun    (o_overrun)
  );

  assign o_res_count_x       = res_counts.x;
  assign o_res_count_y       = res_counts.y;
  assign o_res_count_isect   = res_counts.isect;
  assign o_res_count_symdiff = res_counts.symdiff;

endmodule

`default_nettype wire

//--- logic/corr_window_timer.sv
`timescale 1ns/1ps
`default_nettype none

module corr_window_timer import corr_pkg::*; (
  input  wire               i_clk,
  input  wire               i_arst_n,
  input  wire               i_enable,
  input  wire  [EXP_W-1:0]  i_window_exp,
  output logic              o_sample,
  output logic              o_first,
  output logic              o_last,
  output logic [EXP_W-1:0]  o_exp
);

  timer_state_e      state_q;
  logic [EXP_W-1:0]  exp_q;
  logic [TIME_W-1:0] cnt_q;      // samples already taken in this window
  logic [TIME_W:0]   span;       // window length, 2^exp
  logic [TIME_W-1:0] last_idx;   // cnt_q value on the last sample

  assign o_exp    = (state_q == IDLE) ? i_window_exp : exp_q; // follows the input until started
  assign span     = (TIME_W + 1)'(1) << o_exp;
  assign last_idx = TIME_W'(span - 1'b1);

  assign o_sample = i_enable;    // idle cycle with enable is already the first sample
  assign o_first  = o_sample && (cnt_q == '0);
  assign o_last   = o_sample && (cnt_q == last_idx);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (i_enable) begin
      state_q <= RUN;                          // no way back to idle except reset
      cnt_q   <= o_last ? '0 : cnt_q + 1'b1;   // disabled cycles hold the count
    end
  end

  // exponent is frozen for the whole run
  always_ff @(posedge i_clk) begin
    if (state_q == IDLE) begin
      exp_q <= i_window_exp;
    end
  end

  // a sample is both first and last exactly when the window is one sample long
  a_first_last_exp0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_sample |-> ((o_first && o_last) == (o_exp == '0)));

endmodule

`default_nettype wire
